// ==== fix_parser.f ====
+incdir+include
logic/fix_pkg.sv
logic/fix_lexer.sv
logic/fix_field_extract.sv
logic/fix_msg_check.sv
logic/fix_parser.sv
test/fix_parser_tb.sv

// ==== Makefile ====
# Verilator build and regression run for the FIX parser.
# Any variable can be overridden on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= fix_parser_tb
FILELIST  ?= fix_parser.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes.
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation reported failure."; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No pass message in $(LOG)."; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/fix_parser_tb.sv ====
// Testbench for the FIX tag=value parser.
// Sends built messages with random idle gaps and checks every field strobe and every
// message verdict, including their latency, against a reference model of the parsing rules.
`timescale 1ns/10ps
`include "fix_params.svh"

module fix_parser_tb;

	localparam int VW = `FIX_VALUE_BYTES * 8;

	logic                          clk;
	logic                          rst;
	logic [7:0]                    byte_i;
	logic                          byte_valid_i;
	logic                          field_valid_o;
	logic [`FIX_TAG_W-1:0]         field_tag_o;
	logic [VW-1:0]                 field_value_o;
	logic [fix_pkg::VAL_LEN_W-1:0] field_len_o;
	logic                          field_err_o;
	logic                          msg_done_o;
	logic                          msg_ok_o;
	logic [7:0]                    msg_fields_o;

	int cycle = 0; // Posedges seen so far.
	int cycle_limit = 0;
	int errors = 0;
	int checks = 0;
	logic [15:0] lfsr = 16'd12;

	string msgs[$];
	int msg_test[$];
	string test_names[$];

	string exp_name_q[$]; // Expected fields, one entry per SOH.
	logic [`FIX_TAG_W-1:0] exp_tag_q[$];
	logic [VW-1:0] exp_val_q[$];
	int exp_len_q[$];
	bit exp_err_q[$];
	string done_name_q[$]; // Expected verdicts, one per message.
	bit done_ok_q[$];
	int done_cnt_q[$];
	int soh_cycle_q[$]; // Edge at which each SOH byte is sampled.
	int end_cycle_q[$]; // Edge at which each final SOH is sampled.

	fix_parser dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	initial begin
		wait (cycle_limit > 0);
		while (cycle < cycle_limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic bit next_random_bit();
		bit lsb;
		lsb = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return lsb;
	endfunction

	function automatic int random_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | next_random_bit();
		end
		return v;
	endfunction

	// Messages are written with '|' standing in for SOH.
	function automatic logic [7:0] to_wire(byte c);
		return (c == "|") ? `FIX_SOH : c;
	endfunction

	function automatic int checksum_of(string s);
		int sum;
		sum = 0;
		for (int i = 0; i < s.len(); i++) begin
			sum = (sum + to_wire(s.getc(i))) % 256;
		end
		return sum;
	endfunction

	function automatic string build_message(string body);
		return {body, "10=", $sformatf("%03d", checksum_of(body)), "|"};
	endfunction

	function automatic string corrupt_checksum(string m);
		byte d;
		d = m.getc(m.len() - 2); // Last digit of the checksum.
		m.putc(m.len() - 2, (d == "9") ? byte'("0") : byte'(d + 1));
		return m;
	endfunction

	// Reference model. Splits one message into expected fields and its verdict.
	function automatic void expect_message(string name, string msg);
		logic [7:0] b;
		logic [`FIX_TAG_W-1:0] tag;
		logic [VW-1:0] val;
		int sum, field_sum, ndig, len, nfields, cks;
		bit err, in_val, first8, digits;
		sum = 0;
		field_sum = 0;
		nfields = 0;
		first8 = 0;
		tag = '0;
		val = '0;
		ndig = 0;
		len = 0;
		err = 0;
		in_val = 0;
		for (int i = 0; i < msg.len(); i++) begin
			b = to_wire(msg.getc(i));
			sum = (sum + b) % 256;
			if (!in_val) begin
				if (b == `FIX_EQ) begin
					err = err | (ndig == 0);
					in_val = 1;
				end else if (b < "0" || b > "9" || ndig == 4) begin
					err = 1;
				end else begin
					tag = tag * 10 + (b - "0");
					ndig++;
				end
			end else if (b == `FIX_SOH) begin
				exp_name_q.push_back(name);
				exp_tag_q.push_back(tag);
				exp_val_q.push_back(val);
				exp_len_q.push_back(len);
				exp_err_q.push_back(err);
				nfields++;
				if (nfields == 1) begin
					first8 = (tag == 8);
				end
				if (tag == 10) begin
					digits = (len == 3);
					cks = 0;
					for (int k = 0; k < 3; k++) begin
						if (val[8*k +: 8] < "0" || val[8*k +: 8] > "9") begin
							digits = 0;
						end
						cks = cks * 10 + val[8*k +: 8] - "0";
					end
					done_name_q.push_back(name);
					done_ok_q.push_back(first8 && digits && cks == field_sum);
					done_cnt_q.push_back(nfields);
				end
				field_sum = sum; // Sum of everything before the next tag.
				tag = '0;
				val = '0;
				ndig = 0;
				len = 0;
				err = 0;
				in_val = 0;
			end else if (len < `FIX_VALUE_BYTES) begin
				val[8*len +: 8] = b;
				len++;
			end else begin
				err = 1;
			end
		end
	endfunction

	task automatic compare(string test_name, string what, logic [VW-1:0] expected,
			logic [VW-1:0] actual);
		checks++;
		assert (expected == actual) else begin
			$display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic check_field();
		string name;
		if (exp_tag_q.size() == 0) begin
			$display("Field strobe at cycle %0d arrived with no field pending.", cycle);
			errors++;
		end else begin
			name = exp_name_q.pop_front();
			compare(name, "field tag", exp_tag_q.pop_front(), field_tag_o);
			compare(name, "field value", exp_val_q.pop_front(), field_value_o);
			compare(name, "field length", exp_len_q.pop_front(), field_len_o);
			compare(name, "field error", exp_err_q.pop_front(), field_err_o);
			compare(name, "field strobe cycle", soh_cycle_q.pop_front() + 2, cycle);
		end
	endtask

	task automatic check_done();
		string name;
		if (done_ok_q.size() == 0) begin
			$display("Message result at cycle %0d arrived with no message pending.", cycle);
			errors++;
		end else begin
			name = done_name_q.pop_front();
			compare(name, "msg ok", done_ok_q.pop_front(), msg_ok_o);
			compare(name, "msg field count", done_cnt_q.pop_front(), msg_fields_o);
			compare(name, "msg done cycle", end_cycle_q.pop_front() + 3, cycle);
		end
	endtask

	always @(negedge clk) begin
		if (!rst && field_valid_o) begin
			check_field();
		end
		if (!rst && msg_done_o) begin
			check_done();
		end
	end

	// Starts and ends on a falling edge.
	task automatic send_message(string msg);
		for (int i = 0; i < msg.len(); i++) begin
			repeat (random_bits(2)) @(negedge clk);
			byte_i = to_wire(msg.getc(i));
			byte_valid_i = 1'b1;
			if (byte_i == `FIX_SOH) begin
				soh_cycle_q.push_back(cycle + 1);
			end
			if (i == msg.len() - 1) begin
				end_cycle_q.push_back(cycle + 1);
			end
			@(negedge clk);
			byte_valid_i = 1'b0;
		end
	endtask

	task automatic wait_drain(string name);
		int idle;
		idle = 0;
		while ((exp_tag_q.size() != 0 || done_ok_q.size() != 0) && idle < 20) begin
			@(negedge clk);
			idle++;
		end
		if (exp_tag_q.size() != 0 || done_ok_q.size() != 0) begin
			$display("%s: %0d field strobes and %0d message results never arrived.", name,
				exp_tag_q.size(), done_ok_q.size());
			errors++;
			exp_name_q.delete();
			exp_tag_q.delete();
			exp_val_q.delete();
			exp_len_q.delete();
			exp_err_q.delete();
			done_name_q.delete();
			done_ok_q.delete();
			done_cnt_q.delete();
			soh_cycle_q.delete();
			end_cycle_q.delete();
		end
		repeat (4) @(negedge clk); // Room for any stray strobe to show up.
	endtask

	initial begin
		string body;
		int total, first_err, n;
		rst = 1'b1;
		byte_i = 8'h00;
		byte_valid_i = 1'b0;
		test_names = '{"valid_order", "bad_checksum", "first_tag_not_8", "long_value",
			"bad_tags", "eq_and_empty_value", "back_to_back"};
		msgs.push_back(build_message("8=FIX.4.2|9=12|35=D|49=SENDER|56=TARGET|11=ORD1|"));
		msgs.push_back(corrupt_checksum(build_message("8=FIX.4.2|35=D|49=AB|")));
		msgs.push_back(build_message("35=D|8=FIX.4.2|49=XY|"));
		msgs.push_back(build_message(
			"8=FIX.4.2|58=0123456789ABCDEFGHIJKLMNOPQRSTUVWXYZabcd|"));
		msgs.push_back(build_message("8=FIX.4.2|3A5=x|=empty|12345=v|"));
		msgs.push_back(build_message("8=FIX.4.2|58=a=b==c|112=|"));
		msg_test = '{0, 1, 2, 3, 4, 5};
		for (int m = 0; m < 6; m++) begin
			body = $sformatf("8=FIX.4.4|34=%0d|58=", m + 1);
			n = random_bits(4);
			for (int k = 0; k < n; k++) begin
				body = {body, $sformatf("%c", 8'h61 + random_bits(4))};
			end
			body = {body, "|"};
			msgs.push_back((m == 2) ? corrupt_checksum(build_message(body)) :
				build_message(body));
			msg_test.push_back(6);
		end
		total = 0;
		foreach (msgs[i]) begin
			total += msgs[i].len();
		end
		cycle_limit = total * 5 + 100 + 40 * test_names.size();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		foreach (test_names[t]) begin
			first_err = errors;
			foreach (msgs[i]) begin
				if (msg_test[i] == t) begin
					expect_message(test_names[t], msgs[i]);
					send_message(msgs[i]);
				end
			end
			wait_drain(test_names[t]);
			$display("Test %s finished with %0d errors.", test_names[t], errors - first_err);
		end
		$display("Tests %0d, checks %0d, errors %0d.", test_names.size(), checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/fix_parser.sv ====
// Top level of the FIX tag=value parser.
// Byte stream in, one strobe per parsed field out, and a verdict at the end of each message.
// Chain is lexer, then field extractor, then message checker.
`timescale 1ns/10ps
`include "fix_params.svh"

module fix_parser (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [7:0]                    byte_i,
	input  logic                          byte_valid_i,
	output logic                          field_valid_o,
	output logic [`FIX_TAG_W-1:0]         field_tag_o,
	output logic [fix_pkg::VAL_W-1:0]     field_value_o,
	output logic [fix_pkg::VAL_LEN_W-1:0] field_len_o,
	output logic                          field_err_o,
	output logic                          msg_done_o,
	output logic                          msg_ok_o,
	output logic [7:0]                    msg_fields_o
);

	import fix_pkg::*;

	logic       tok_valid;
	tok_kind_e  tok_kind;
	logic [7:0] tok_byte;

	fix_lexer u_lexer (
		.clk(clk),
		.rst(rst),
		.byte_i(byte_i),
		.byte_valid_i(byte_valid_i),
		.tok_valid_o(tok_valid),
		.tok_kind_o(tok_kind),
		.tok_byte_o(tok_byte)
	);

	fix_field_extract u_extract (
		.clk(clk),
		.rst(rst),
		.tok_valid_i(tok_valid),
		.tok_kind_i(tok_kind),
		.tok_byte_i(tok_byte),
		.field_valid_o(field_valid_o),
		.field_tag_o(field_tag_o),
		.field_value_o(field_value_o),
		.field_len_o(field_len_o),
		.field_err_o(field_err_o)
	);

	// The checker also sees the raw tokens for the checksum.
	fix_msg_check u_check (
		.clk(clk),
		.rst(rst),
		.tok_valid_i(tok_valid),
		.tok_byte_i(tok_byte),
		.field_valid_i(field_valid_o),
		.field_tag_i(field_tag_o),
		.field_value_i(field_value_o),
		.msg_done_o(msg_done_o),
		.msg_ok_o(msg_ok_o),
		.msg_fields_o(msg_fields_o)
	);

endmodule

// ==== logic/fix_msg_check.sv ====
// Result stage of the FIX parser.
// Keeps the running modulo-256 sum and the field count of the current message and,
// on the checksum field (tag 10), reports whether the message is well formed.
`timescale 1ns/10ps
`include "fix_params.svh"

module fix_msg_check (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      tok_valid_i,
	input  logic [7:0]                tok_byte_i,
	input  logic                      field_valid_i,
	input  logic [`FIX_TAG_W-1:0]     field_tag_i,
	input  logic [fix_pkg::VAL_W-1:0] field_value_i,
	output logic                      msg_done_o,
	output logic                      msg_ok_o,
	output logic [7:0]                msg_fields_o
);

	import fix_pkg::*;

	logic [7:0] sum;
	logic [7:0] sum_inc;
	logic [7:0] snap; // Sum through the latest SOH.
	logic [7:0] snap_prev; // Sum through the SOH before that.
	logic [7:0] count;
	logic       seen_begin;

	logic       is_cks;
	logic       digits_ok;
	logic [9:0] cks_num;

	assign sum_inc = sum + tok_byte_i;
	assign is_cks = (field_tag_i == TAG_CHECKSUM);

	// Exactly three ASCII digits, so the fourth byte must be empty.
	assign digits_ok = (field_value_i[7:4] == 4'h3) && (field_value_i[3:0] <= 4'd9) &&
		(field_value_i[15:12] == 4'h3) && (field_value_i[11:8] <= 4'd9) &&
		(field_value_i[23:20] == 4'h3) && (field_value_i[19:16] <= 4'd9) &&
		(field_value_i[31:24] == 8'h00);
	assign cks_num = {6'd0, field_value_i[3:0]} * 10'd100 +
		{6'd0, field_value_i[11:8]} * 10'd10 + {6'd0, field_value_i[19:16]};

	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= '0;
			snap <= '0;
			snap_prev <= '0;
			count <= '0;
			seen_begin <= 1'b0;
			msg_done_o <= 1'b0;
		end else begin
			msg_done_o <= 1'b0;
			if (tok_valid_i) begin
				sum <= sum_inc;
				if (tok_byte_i == `FIX_SOH) begin
					snap <= sum_inc;
					snap_prev <= snap; // This SOH may close the checksum field itself.
				end
			end
			if (field_valid_i) begin
				if (is_cks) begin
					msg_done_o <= 1'b1;
					sum <= tok_valid_i ? tok_byte_i : 8'h00; // Next message may have started.
					snap <= '0;
					snap_prev <= '0;
					count <= '0;
					seen_begin <= 1'b0;
				end else begin
					count <= count + 8'd1;
					if (count == '0 && field_tag_i == TAG_BEGIN_STRING) begin
						seen_begin <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid_i && is_cks) begin
			msg_ok_o <= seen_begin && digits_ok && (cks_num == {2'b00, snap_prev});
			msg_fields_o <= count + 8'd1;
		end
	end

endmodule

// ==== logic/fix_field_extract.sv ====
// Execute stage of the FIX parser.
// Accumulates the decimal tag and the value bytes of each field from the token stream
// and emits the finished field with a one-cycle strobe when its SOH arrives.
`timescale 1ns/10ps
`include "fix_params.svh"

module fix_field_extract (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         tok_valid_i,
	input  fix_pkg::tok_kind_e           tok_kind_i,
	input  logic [7:0]                   tok_byte_i,
	output logic                         field_valid_o,
	output logic [`FIX_TAG_W-1:0]        field_tag_o,
	output logic [fix_pkg::VAL_W-1:0]    field_value_o,
	output logic [fix_pkg::VAL_LEN_W-1:0] field_len_o,
	output logic                         field_err_o
);

	import fix_pkg::*;

	logic [`FIX_TAG_W-1:0] tag_acc;
	logic [2:0]            tag_cnt; // Digits taken so far.
	logic [VAL_W-1:0]      val_buf;
	logic [VAL_LEN_W-1:0]  val_len;
	logic                  acc_err;

	logic                  is_digit;
	logic [`FIX_TAG_W-1:0] tag_step;

	assign is_digit = (tok_byte_i >= 8'h30) && (tok_byte_i <= 8'h39);

	// Ten times the tag so far plus the new digit, which is the low nibble of its ASCII code.
	assign tag_step = (tag_acc << 3) + (tag_acc << 1) +
		{{(`FIX_TAG_W-4){1'b0}}, tok_byte_i[3:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_acc <= '0;
			tag_cnt <= '0;
			val_buf <= '0;
			val_len <= '0;
			acc_err <= 1'b0;
			field_valid_o <= 1'b0;
		end else begin
			field_valid_o <= 1'b0;
			if (tok_valid_i) begin
				case (tok_kind_i)
					TOK_TAG_CHAR: begin
						if (!is_digit || tag_cnt == TAG_DIGITS) begin
							acc_err <= 1'b1;
						end else begin
							tag_acc <= tag_step;
							tag_cnt <= tag_cnt + 3'd1;
						end
					end
					TOK_EQ: begin
						if (tag_cnt == '0) begin
							acc_err <= 1'b1; // Nothing came before the '='.
						end
					end
					TOK_VAL_CHAR: begin
						if (val_len < `FIX_VALUE_BYTES) begin
							val_buf[8*val_len +: 8] <= tok_byte_i; // First byte lands lowest.
							val_len <= val_len + 1'b1;
						end else begin
							acc_err <= 1'b1; // Overlong value, the byte is lost.
						end
					end
					TOK_SOH: begin
						field_valid_o <= 1'b1;
						tag_acc <= '0;
						tag_cnt <= '0;
						val_buf <= '0; // Keeps unused bytes of the next field at zero.
						val_len <= '0;
						acc_err <= 1'b0;
					end
					default: acc_err <= 1'b1;
				endcase
			end
		end
	end

	// Field results are captured on the same SOH that clears the accumulators.
	always_ff @(posedge clk) begin
		if (tok_valid_i && tok_kind_i == TOK_SOH) begin
			field_tag_o <= tag_acc;
			field_value_o <= val_buf;
			field_len_o <= val_len;
			field_err_o <= acc_err;
		end
	end

	a_len_in_range: assert property (@(posedge clk) disable iff (rst)
		field_valid_o |-> field_len_o <= `FIX_VALUE_BYTES);

endmodule

// ==== logic/fix_lexer.sv ====
// Decode stage of the FIX parser.
// Samples every input byte, classifies it as a tag character, '=', a value character
// or SOH, and presents it one cycle after sampling as a registered token.
`timescale 1ns/10ps
`include "fix_params.svh"

module fix_lexer (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         byte_i,
	input  logic               byte_valid_i,
	output logic               tok_valid_o,
	output fix_pkg::tok_kind_e tok_kind_o,
	output logic [7:0]         tok_byte_o
);

	import fix_pkg::*;

	lex_state_e state;
	lex_state_e state_next;
	tok_kind_e  kind;
	logic [7:0] byte_q; // Input byte as sampled.
	logic       valid_q;

	// Token kind depends only on where we are in the field.
	always_comb begin
		state_next = state;
		kind = TOK_TAG_CHAR;
		case (state)
			LEX_TAG: begin
				if (byte_q == `FIX_EQ) begin
					kind = TOK_EQ;
					state_next = LEX_VALUE;
				end else begin
					kind = TOK_TAG_CHAR;
				end
			end
			LEX_VALUE: begin
				if (byte_q == `FIX_SOH) begin
					kind = TOK_SOH;
					state_next = LEX_TAG;
				end else begin
					kind = TOK_VAL_CHAR; // An '=' here is plain value data.
				end
			end
			default: state_next = LEX_TAG;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LEX_TAG;
			valid_q <= 1'b0;
			tok_valid_o <= 1'b0;
		end else begin
			valid_q <= byte_valid_i;
			tok_valid_o <= valid_q;
			if (valid_q) begin
				state <= state_next; // Only real bytes move the lexer.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid_i) begin
			byte_q <= byte_i;
		end
		if (valid_q) begin
			tok_kind_o <= kind;
			tok_byte_o <= byte_q;
		end
	end

	// A token appears only for a byte that was actually strobed in.
	a_no_spurious_token: assert property (@(posedge clk) disable iff (rst)
		tok_valid_o |-> $past(byte_valid_i, 2));

endmodule

// ==== logic/fix_pkg.sv ====
// Shared types for the FIX parser pipeline.
// Modules import this package for token kinds, lexer states and derived widths.
`include "fix_params.svh"

package fix_pkg;

	// Kind of each input byte as seen by the lexer.
	typedef enum logic [1:0] {
		TOK_TAG_CHAR,
		TOK_EQ,
		TOK_VAL_CHAR,
		TOK_SOH
	} tok_kind_e;

	// Lexer position inside a field.
	typedef enum logic {
		LEX_TAG,
		LEX_VALUE
	} lex_state_e;

	localparam int VAL_W = `FIX_VALUE_BYTES * 8; // Value bus width in bits.
	localparam int VAL_LEN_W = $clog2(`FIX_VALUE_BYTES + 1); // Holds 0 to FIX_VALUE_BYTES.
	localparam int TAG_DIGITS = 4; // Most digits accepted in a tag.

	localparam logic [`FIX_TAG_W-1:0] TAG_BEGIN_STRING = 8; // Must open every message.
	localparam logic [`FIX_TAG_W-1:0] TAG_CHECKSUM = 10; // Closes every message.

endpackage

// ==== include/fix_params.svh ====
// Sizing and special byte values for the FIX tag=value parser.
// Included by the package and by every RTL module that needs a width or a delimiter.
`ifndef FIX_PARAMS_SVH
`define FIX_PARAMS_SVH

// Largest number of value bytes kept per field. Longer values are cut and flagged.
`define FIX_VALUE_BYTES 32

// Width of the binary tag number. Four decimal digits fit.
`define FIX_TAG_W 16

`define FIX_SOH 8'h01 // Field delimiter.
`define FIX_EQ 8'h3D // Separates tag from value.

`endif
